/* Makefile */
VERILATOR ?= verilator
TOP       ?= autotest_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard design/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/autotest_macros.svh */
// record layout, SD block, signature and timeout macros
`ifndef AUTOTEST_MACROS_SVH
`define AUTOTEST_MACROS_SVH

// payload sizes in bytes
`define AT_STIM_BYTES 4
`define AT_RESULT_BYTES 4
`define AT_SIG_BYTES 4
`define AT_EXEC_BYTES 8

`define AT_BLOCK_BYTES 512

// byte offsets inside a record
`define AT_STIM_BASE (`AT_SIG_BYTES)
`define AT_EXPECT_BASE (`AT_STIM_BASE + `AT_STIM_BYTES)
`define AT_RESULT_BASE (`AT_EXPECT_BASE + `AT_RESULT_BYTES)
`define AT_EXEC_BASE (`AT_RESULT_BASE + `AT_RESULT_BYTES)

// first block of the session
`define AT_START_BLOCK 32'h100000

`define AT_SIGNATURE 32'hAABBCCDD

// cycles before a silent UUT is given up on
`define AT_TIMEOUT_CYCLES 200

`endif

/* design/autotest_pkg.sv */
// payload types and sequencer state encoding
`include "autotest_macros.svh"

package autotest_pkg;

  typedef logic [31:0] sig_t;
  typedef logic [`AT_STIM_BYTES*8-1:0] stim_t;
  typedef logic [`AT_RESULT_BYTES*8-1:0] result_t;
  typedef logic [63:0] exec_time_t;
  typedef logic [31:0] block_addr_t;
  typedef logic [9:0] byte_num_t;

  typedef enum logic [3:0] {
    S_IDLE,
    S_HOST_RST,
    S_HOST_WAIT,
    S_BLOCK_START,
    S_RD_BLOCK,
    S_RD_BLOCK_WAIT,
    S_RD_BYTE,
    S_RD_BYTE_WAIT,
    S_CHECK,
    S_RUN_START,
    S_RUN_WAIT,
    S_WR_BLOCK,
    S_WR_SETTLE,
    S_WR_BYTE,
    S_WR_BYTE_WAIT,
    S_NEXT_BLOCK
  } seq_state_e;

endpackage

/* design/autotest_top.sv */
// self-test controller top level, instances and wiring
`timescale 1ns/1ps
`include "autotest_macros.svh"

module autotest_top (
  input  logic clk,
  input  logic rst,
  input  logic start_i,
  output logic idle_o,
  input  logic sd_busy_i,
  output logic sd_rst_o,
  output logic sd_r_block_o,
  output logic sd_r_byte_o,
  output logic sd_w_block_o,
  output logic sd_w_byte_o,
  output autotest_pkg::block_addr_t sd_block_addr_o,
  input  logic [7:0] sd_data_i,
  output logic [7:0] sd_data_o,
  output logic uut_rst_o,
  input  logic uut_end_i,
  input  logic uut_err_i,
  output autotest_pkg::stim_t uut_stim_o,
  input  autotest_pkg::result_t uut_result_i,
  output logic [31:0] error_count_o
);

  autotest_pkg::sig_t signature;
  autotest_pkg::result_t expected;
  autotest_pkg::byte_num_t byte_num;

  vector_load_if u_load ();
  run_if u_run ();

  test_sequencer u_sequencer (
    .clk(clk), .rst(rst), .start_i(start_i), .idle_o(idle_o),
    .sd_busy_i(sd_busy_i), .sd_rst_o(sd_rst_o),
    .sd_r_block_o(sd_r_block_o), .sd_r_byte_o(sd_r_byte_o),
    .sd_w_block_o(sd_w_block_o), .sd_w_byte_o(sd_w_byte_o),
    .sd_block_addr_o(sd_block_addr_o), .sd_data_i(sd_data_i),
    .signature_i(signature), .load(u_load.feed), .run(u_run.ctrl),
    .byte_num_o(byte_num)
  );

  // signature arrives most significant byte first
  vector_store #(.payload_t(autotest_pkg::sig_t), .BASE(0), .MSB_FIRST(1'b1)) u_sig_store (
    .clk(clk), .rst(rst), .load(u_load.store), .value_o(signature)
  );

  vector_store #(.payload_t(autotest_pkg::stim_t), .BASE(`AT_STIM_BASE)) u_stim_store (
    .clk(clk), .rst(rst), .load(u_load.store), .value_o(uut_stim_o)
  );

  vector_store #(.payload_t(autotest_pkg::result_t), .BASE(`AT_EXPECT_BASE)) u_expect_store (
    .clk(clk), .rst(rst), .load(u_load.store), .value_o(expected)
  );

  // a session always opens with the host reset, which clears the error count
  test_runner u_runner (
    .clk(clk), .rst(rst), .clear_errors_i(sd_rst_o), .run(u_run.exec),
    .uut_rst_o(uut_rst_o), .uut_end_i(uut_end_i), .uut_err_i(uut_err_i),
    .uut_result_i(uut_result_i), .expected_i(expected),
    .error_count_o(error_count_o)
  );

  record_formatter u_formatter (
    .clk(clk), .rst(rst), .byte_num_i(byte_num), .signature_i(signature),
    .stim_i(uut_stim_o), .expected_i(expected), .captured_i(u_run.captured),
    .exec_time_i(u_run.exec_time), .data_o(sd_data_o)
  );

endmodule

/* design/record_formatter.sv */
// registered byte selection for the result record write-back
`timescale 1ns/1ps
`include "autotest_macros.svh"

module record_formatter (
  input  logic clk,
  input  logic rst,
  input  autotest_pkg::byte_num_t byte_num_i,
  input  autotest_pkg::sig_t signature_i,
  input  autotest_pkg::stim_t stim_i,
  input  autotest_pkg::result_t expected_i,
  input  autotest_pkg::result_t captured_i,
  input  autotest_pkg::exec_time_t exec_time_i,
  output logic [7:0] data_o
);

  logic [7:0] next_byte;
  logic [7:0] data_q;

  always_comb begin
    // padding past the last field
    next_byte = 8'hFF;
    for (int k = 0; k < `AT_SIG_BYTES; k++) begin
      if (byte_num_i == autotest_pkg::byte_num_t'(k))
        next_byte = signature_i[8*(`AT_SIG_BYTES-1-k) +: 8];
    end
    for (int k = 0; k < `AT_STIM_BYTES; k++) begin
      if (byte_num_i == autotest_pkg::byte_num_t'(`AT_STIM_BASE + k))
        next_byte = stim_i[8*k +: 8];
    end
    for (int k = 0; k < `AT_RESULT_BYTES; k++) begin
      if (byte_num_i == autotest_pkg::byte_num_t'(`AT_EXPECT_BASE + k))
        next_byte = expected_i[8*k +: 8];
      if (byte_num_i == autotest_pkg::byte_num_t'(`AT_RESULT_BASE + k))
        next_byte = captured_i[8*k +: 8];
    end
    for (int k = 0; k < `AT_EXEC_BYTES; k++) begin
      if (byte_num_i == autotest_pkg::byte_num_t'(`AT_EXEC_BASE + k))
        next_byte = exec_time_i[8*k +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) data_q <= 8'hFF;
    else data_q <= next_byte;
  end

  assign data_o = data_q;

endmodule

/* design/run_if.sv */
// interface between the sequencer and the test runner
`timescale 1ns/1ps

interface run_if;

  logic start;
  logic done;
  autotest_pkg::exec_time_t exec_time;
  autotest_pkg::result_t captured;

  // sequencer side
  modport ctrl (output start, input done, input exec_time, input captured);

  // runner side
  modport exec (input start, output done, output exec_time, output captured);

endinterface

/* design/test_runner.sv */
// UUT reset control, execution timer, result capture and error counter
`timescale 1ns/1ps
`include "autotest_macros.svh"

module test_runner (
  input  logic clk,
  input  logic rst,
  input  logic clear_errors_i,
  run_if.exec run,
  output logic uut_rst_o,
  input  logic uut_end_i,
  input  logic uut_err_i,
  input  autotest_pkg::result_t uut_result_i,
  input  autotest_pkg::result_t expected_i,
  output logic [31:0] error_count_o
);

  logic running_q;
  logic done_q;
  logic run_end;
  logic mismatch;
  autotest_pkg::exec_time_t exec_time_q;
  autotest_pkg::result_t captured_q;
  logic [31:0] error_count_q;

  // UUT finished, flagged an error, or ran out of time
  assign run_end = uut_end_i || uut_err_i ||
                   (exec_time_q == autotest_pkg::exec_time_t'(`AT_TIMEOUT_CYCLES));
  assign mismatch = (uut_result_i != expected_i) || uut_err_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      running_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (run.start) begin
        running_q <= 1'b1;
      end else if (running_q && run_end) begin
        running_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run.start) begin
      exec_time_q <= '0;
    end else if (running_q) begin
      if (run_end) captured_q <= uut_result_i;
      else exec_time_q <= exec_time_q + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear_errors_i) error_count_q <= '0;
    else if (running_q && run_end && mismatch) error_count_q <= error_count_q + 32'd1;
  end

  // held in reset outside a run
  assign uut_rst_o = !running_q;
  assign run.done = done_q;
  assign run.exec_time = exec_time_q;
  assign run.captured = captured_q;
  assign error_count_o = error_count_q;

endmodule

/* design/test_sequencer.sv */
// session FSM with block and byte counters and SD command strobes
`timescale 1ns/1ps
`include "autotest_macros.svh"

module test_sequencer (
  input  logic clk,
  input  logic rst,
  input  logic start_i,
  output logic idle_o,
  input  logic sd_busy_i,
  output logic sd_rst_o,
  output logic sd_r_block_o,
  output logic sd_r_byte_o,
  output logic sd_w_block_o,
  output logic sd_w_byte_o,
  output autotest_pkg::block_addr_t sd_block_addr_o,
  input  logic [7:0] sd_data_i,
  input  autotest_pkg::sig_t signature_i,
  vector_load_if.feed load,
  run_if.ctrl run,
  output autotest_pkg::byte_num_t byte_num_o
);

  localparam autotest_pkg::byte_num_t LAST_BYTE =
    autotest_pkg::byte_num_t'(`AT_BLOCK_BYTES - 1);

  autotest_pkg::seq_state_e state_q;
  autotest_pkg::seq_state_e state_d;
  autotest_pkg::block_addr_t block_addr_q;
  autotest_pkg::byte_num_t byte_cnt_q;
  logic byte_zero;
  logic byte_inc;
  logic addr_load;
  logic addr_inc;

  always_comb begin
    state_d = state_q;
    byte_zero = 1'b0;
    byte_inc = 1'b0;
    addr_load = 1'b0;
    addr_inc = 1'b0;
    sd_rst_o = 1'b0;
    sd_r_block_o = 1'b0;
    sd_r_byte_o = 1'b0;
    sd_w_block_o = 1'b0;
    sd_w_byte_o = 1'b0;
    load.clear = 1'b0;
    load.write = 1'b0;
    run.start = 1'b0;
    case (state_q)
      autotest_pkg::S_IDLE: begin
        if (start_i) begin
          addr_load = 1'b1;
          state_d = autotest_pkg::S_HOST_RST;
        end
      end
      autotest_pkg::S_HOST_RST: begin
        sd_rst_o = 1'b1;
        if (sd_busy_i) state_d = autotest_pkg::S_HOST_WAIT;
      end
      autotest_pkg::S_HOST_WAIT: begin
        if (!sd_busy_i) state_d = autotest_pkg::S_BLOCK_START;
      end
      autotest_pkg::S_BLOCK_START: begin
        load.clear = 1'b1;
        byte_zero = 1'b1;
        state_d = autotest_pkg::S_RD_BLOCK;
      end
      autotest_pkg::S_RD_BLOCK: begin
        sd_r_block_o = 1'b1;
        if (sd_busy_i) state_d = autotest_pkg::S_RD_BLOCK_WAIT;
      end
      autotest_pkg::S_RD_BLOCK_WAIT: begin
        sd_r_block_o = 1'b1;
        if (!sd_busy_i) state_d = autotest_pkg::S_RD_BYTE;
      end
      autotest_pkg::S_RD_BYTE: begin
        sd_r_block_o = 1'b1;
        sd_r_byte_o = 1'b1;
        if (sd_busy_i) state_d = autotest_pkg::S_RD_BYTE_WAIT;
      end
      autotest_pkg::S_RD_BYTE_WAIT: begin
        sd_r_block_o = 1'b1;
        if (!sd_busy_i) begin
          // byte on sd_data_i is valid now
          load.write = 1'b1;
          byte_inc = 1'b1;
          state_d = (byte_cnt_q == LAST_BYTE) ? autotest_pkg::S_CHECK :
                                                autotest_pkg::S_RD_BYTE;
        end
      end
      autotest_pkg::S_CHECK: begin
        state_d = (signature_i == `AT_SIGNATURE) ? autotest_pkg::S_RUN_START :
                                                   autotest_pkg::S_IDLE;
      end
      autotest_pkg::S_RUN_START: begin
        run.start = 1'b1;
        state_d = autotest_pkg::S_RUN_WAIT;
      end
      autotest_pkg::S_RUN_WAIT: begin
        if (run.done) begin
          byte_zero = 1'b1;
          state_d = autotest_pkg::S_WR_BLOCK;
        end
      end
      autotest_pkg::S_WR_BLOCK: begin
        sd_w_block_o = 1'b1;
        if (!sd_busy_i) state_d = autotest_pkg::S_WR_BYTE;
      end
      autotest_pkg::S_WR_SETTLE: begin
        // formatter output catches up with the new byte number
        sd_w_block_o = 1'b1;
        state_d = autotest_pkg::S_WR_BYTE;
      end
      autotest_pkg::S_WR_BYTE: begin
        sd_w_block_o = 1'b1;
        sd_w_byte_o = 1'b1;
        if (sd_busy_i) state_d = autotest_pkg::S_WR_BYTE_WAIT;
      end
      autotest_pkg::S_WR_BYTE_WAIT: begin
        sd_w_block_o = 1'b1;
        if (!sd_busy_i) begin
          if (byte_cnt_q == LAST_BYTE) begin
            state_d = autotest_pkg::S_NEXT_BLOCK;
          end else begin
            byte_inc = 1'b1;
            state_d = autotest_pkg::S_WR_SETTLE;
          end
        end
      end
      autotest_pkg::S_NEXT_BLOCK: begin
        addr_inc = 1'b1;
        state_d = autotest_pkg::S_BLOCK_START;
      end
      default: state_d = autotest_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= autotest_pkg::S_IDLE;
      block_addr_q <= `AT_START_BLOCK;
      byte_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (addr_load) block_addr_q <= `AT_START_BLOCK;
      else if (addr_inc) block_addr_q <= block_addr_q + 32'd1;
      if (byte_zero) byte_cnt_q <= '0;
      else if (byte_inc) byte_cnt_q <= byte_cnt_q + 10'd1;
    end
  end

  assign idle_o = (state_q == autotest_pkg::S_IDLE);
  assign sd_block_addr_o = block_addr_q;
  assign byte_num_o = byte_cnt_q;
  assign load.byte_num = byte_cnt_q;
  assign load.data = sd_data_i;

endmodule

/* design/vector_load_if.sv */
// interface for the SD read byte stream into the record stores
`timescale 1ns/1ps

interface vector_load_if;

  logic clear;
  logic write;
  autotest_pkg::byte_num_t byte_num;
  logic [7:0] data;

  // sequencer side
  modport feed (output clear, output write, output byte_num, output data);

  // record store side
  modport store (input clear, input write, input byte_num, input data);

endinterface

/* design/vector_store.sv */
// byte-lane register filled from the SD read stream
`timescale 1ns/1ps

module vector_store #(
  parameter type payload_t = logic [31:0],
  parameter int BASE = 0,
  parameter bit MSB_FIRST = 1'b0
) (
  input  logic clk,
  input  logic rst,
  vector_load_if.store load,
  output payload_t value_o
);

  localparam int LANES = $bits(payload_t) / 8;

  payload_t value_q;

  always_ff @(posedge clk) begin
    if (rst || load.clear) begin
      value_q <= '0;
    end else if (load.write) begin
      for (int k = 0; k < LANES; k++) begin
        // byte BASE+k lands in lane k, or the mirrored lane
        if (load.byte_num == autotest_pkg::byte_num_t'(BASE + k)) begin
          value_q[8*(MSB_FIRST ? LANES-1-k : k) +: 8] <= load.data;
        end
      end
    end
  end

  assign value_o = value_q;

endmodule

/* test/autotest_tb.sv */
// testbench for the self-test controller with SD host model, UUT model and checks
`timescale 1ns/1ps
`include "autotest_macros.svh"

module autotest_tb;

  localparam int MAX_REC = 8;
  localparam int SESSION_CYCLES = 200000;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic start = 1'b0;
  logic sd_busy = 1'b0;
  logic [7:0] sd_data = 8'h00;
  logic uut_end = 1'b0;
  logic uut_err = 1'b0;
  autotest_pkg::result_t uut_result = '0;
  logic idle;
  logic sd_rst;
  logic sd_r_block;
  logic sd_r_byte;
  logic sd_w_block;
  logic sd_w_byte;
  logic uut_rst;
  logic [7:0] sd_data_o;
  autotest_pkg::block_addr_t sd_addr;
  autotest_pkg::stim_t uut_stim;
  logic [31:0] error_count;

  // record table loaded from the vector file
  logic [31:0] vec_mem [0:6*MAX_REC];
  autotest_pkg::sig_t sig_a [MAX_REC];
  autotest_pkg::stim_t stim_a [MAX_REC];
  autotest_pkg::result_t exp_a [MAX_REC];
  autotest_pkg::result_t res_a [MAX_REC];
  logic [31:0] lat_a [MAX_REC];
  logic err_a [MAX_REC];
  int rec_count = 0;
  int n_valid = 0;
  int exp_fails = 0;

  int checks = 0;
  int errors = 0;
  integer seed = 32'h6a3fcc81;

  // SD host model state
  int busy_cnt = 0;
  bit rd_open = 1'b0;
  bit wr_open = 1'b0;
  bit pend_read = 1'b0;
  bit want_first = 1'b0;
  int rd_idx = 0;
  int wr_idx = 0;
  logic [31:0] wr_addr = '0;
  logic [31:0] first_read_blk = '0;
  logic [31:0] last_read_blk = '0;
  int blocks_written = 0;
  logic [7:0] wbuf [0:`AT_BLOCK_BYTES-1];

  // UUT model state
  int run_cyc = 0;
  bit run_first = 1'b1;
  int runs_seen = 0;
  int uut_n = 0;

  always #5 clk = ~clk;

  autotest_top u_autotest_top (
    .clk(clk), .rst(rst), .start_i(start), .idle_o(idle),
    .sd_busy_i(sd_busy), .sd_rst_o(sd_rst),
    .sd_r_block_o(sd_r_block), .sd_r_byte_o(sd_r_byte),
    .sd_w_block_o(sd_w_block), .sd_w_byte_o(sd_w_byte),
    .sd_block_addr_o(sd_addr), .sd_data_i(sd_data), .sd_data_o(sd_data_o),
    .uut_rst_o(uut_rst), .uut_end_i(uut_end), .uut_err_i(uut_err),
    .uut_stim_o(uut_stim), .uut_result_i(uut_result), .error_count_o(error_count)
  );

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // byte k of SD block blk as the host serves it
  function automatic logic [7:0] input_byte(input logic [31:0] blk, input int k);
    int n;
    logic [31:0] f;
    n = int'(blk - `AT_START_BLOCK);
    f = blk ^ (k * 32'h9E3779B1);
    if (blk < `AT_START_BLOCK || n >= rec_count) return 8'h00;
    if (k < `AT_STIM_BASE) return sig_a[n][8*(`AT_SIG_BYTES-1-k) +: 8];
    if (k < `AT_EXPECT_BASE) return stim_a[n][8*(k-`AT_STIM_BASE) +: 8];
    if (k < `AT_RESULT_BASE) return exp_a[n][8*(k-`AT_EXPECT_BASE) +: 8];
    return f[31:24] ^ f[23:16] ^ f[15:8] ^ f[7:0];
  endfunction

  // byte k of the result record expected for record n
  function automatic logic [7:0] result_byte(input int n, input int k);
    logic [63:0] et;
    et = (lat_a[n] > `AT_TIMEOUT_CYCLES) ? 64'(`AT_TIMEOUT_CYCLES) : 64'(lat_a[n]);
    if (k < `AT_RESULT_BASE) return input_byte(`AT_START_BLOCK + n, k);
    if (k < `AT_EXEC_BASE) return res_a[n][8*(k-`AT_RESULT_BASE) +: 8];
    if (k < `AT_EXEC_BASE + `AT_EXEC_BYTES) return et[8*(k-`AT_EXEC_BASE) +: 8];
    return 8'hFF;
  endfunction

  task automatic load_vectors();
    int n;
    int base;
    $readmemh("test/autotest_vectors.txt", vec_mem);
    rec_count = int'(vec_mem[0]);
    if (rec_count > MAX_REC) begin
      $display("vector file holds more records than the testbench can take");
      errors++;
      rec_count = MAX_REC;
    end
    for (n = 0; n < rec_count; n++) begin
      base = 1 + 6 * n;
      sig_a[n] = vec_mem[base];
      stim_a[n] = autotest_pkg::stim_t'(vec_mem[base+1]);
      exp_a[n] = autotest_pkg::result_t'(vec_mem[base+2]);
      res_a[n] = autotest_pkg::result_t'(vec_mem[base+3]);
      lat_a[n] = vec_mem[base+4];
      err_a[n] = (vec_mem[base+5] != 0);
    end
    // session ends at the first bad signature
    n_valid = rec_count;
    for (n = rec_count - 1; n >= 0; n--) begin
      if (sig_a[n] != `AT_SIGNATURE) n_valid = n;
    end
    for (n = 0; n < n_valid; n++) begin
      if (res_a[n] != exp_a[n] || (err_a[n] && lat_a[n] <= `AT_TIMEOUT_CYCLES)) exp_fails++;
    end
  endtask

  task automatic check_written_block(input logic [31:0] addr, input int len);
    int n;
    int k;
    n = int'(addr - `AT_START_BLOCK);
    blocks_written++;
    if (n < 0 || n >= n_valid) begin
      $display("write-back to block %h, which holds no valid record", addr);
      errors++;
    end else begin
      compare("write-back length", 64'(len), 64'(`AT_BLOCK_BYTES));
      for (k = 0; k < `AT_BLOCK_BYTES && k < len; k++) begin
        compare($sformatf("sd_data_o byte %0d of block %h", k, addr),
                64'(wbuf[k]), 64'(result_byte(n, k)));
      end
    end
  endtask

  // SD host model with 1 to 4 busy cycles on each command
  always @(negedge clk) begin
    if (rst) begin
      sd_busy = 1'b0;
      busy_cnt = 0;
      rd_open = 1'b0;
      wr_open = 1'b0;
      pend_read = 1'b0;
    end else if (sd_busy) begin
      if (busy_cnt == 0) begin
        sd_busy = 1'b0;
        if (pend_read) begin
          sd_data = input_byte(sd_addr, rd_idx);
          rd_idx++;
          pend_read = 1'b0;
        end
      end else begin
        busy_cnt--;
      end
    end else begin
      if (rd_open && !sd_r_block) rd_open = 1'b0;
      if (wr_open && !sd_w_block) begin
        wr_open = 1'b0;
        check_written_block(wr_addr, wr_idx);
      end
      if (sd_rst) begin
        first_read_blk = '0;
        want_first = 1'b1;
        sd_busy = 1'b1;
        busy_cnt = $random(seed) & 3;
      end else if (sd_r_block && !rd_open) begin
        rd_open = 1'b1;
        rd_idx = 0;
        last_read_blk = sd_addr;
        if (want_first) first_read_blk = sd_addr;
        want_first = 1'b0;
        sd_busy = 1'b1;
        busy_cnt = $random(seed) & 3;
      end else if (sd_r_byte) begin
        pend_read = 1'b1;
        sd_busy = 1'b1;
        busy_cnt = $random(seed) & 3;
      end else if (sd_w_block && !wr_open) begin
        wr_open = 1'b1;
        wr_idx = 0;
        wr_addr = sd_addr;
      end else if (sd_w_byte) begin
        if (wr_idx < `AT_BLOCK_BYTES) wbuf[wr_idx] = sd_data_o;
        wr_idx++;
        sd_busy = 1'b1;
        busy_cnt = $random(seed) & 3;
      end
    end
  end

  // UUT model answering after its latency unless that is past the timeout
  always @(negedge clk) begin
    if (rst || uut_rst) begin
      uut_end = 1'b0;
      uut_err = 1'b0;
      uut_result = '0;
      run_cyc = 0;
      run_first = 1'b1;
    end else begin
      uut_n = int'(sd_addr - `AT_START_BLOCK);
      if (uut_n < 0 || uut_n >= n_valid) begin
        if (run_first) begin
          $display("UUT released while block %h holds no valid record", sd_addr);
          errors++;
        end
      end else begin
        if (run_first) runs_seen++;
        compare("uut_stim_o", 64'(uut_stim), 64'(stim_a[uut_n]));
        uut_result = res_a[uut_n];
        if (run_cyc == int'(lat_a[uut_n])) begin
          if (err_a[uut_n]) uut_err = 1'b1;
          else uut_end = 1'b1;
        end
      end
      run_first = 1'b0;
      run_cyc++;
    end
  end

  task automatic await_idle(input logic level, input int limit, output bit ok);
    int n;
    n = 0;
    while (idle !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    ok = (idle === level);
    if (!ok) begin
      $display("timeout: idle_o did not reach %0d within %0d cycles", level, limit);
      errors++;
    end
  endtask

  task automatic await_host_reset(input logic level, input int limit, output bit ok);
    int n;
    n = 0;
    while (sd_rst !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    ok = (sd_rst === level);
    if (!ok) begin
      $display("timeout: sd_rst_o did not reach %0d within %0d cycles", level, limit);
      errors++;
    end
  endtask

  task automatic check_reset_state();
    int err0;
    err0 = errors;
    compare("idle_o", 64'(idle), 64'd1);
    compare("uut_rst_o", 64'(uut_rst), 64'd1);
    compare("sd_rst_o", 64'(sd_rst), 64'd0);
    compare("sd_r_block_o", 64'(sd_r_block), 64'd0);
    compare("sd_r_byte_o", 64'(sd_r_byte), 64'd0);
    compare("sd_w_block_o", 64'(sd_w_block), 64'd0);
    compare("sd_w_byte_o", 64'(sd_w_byte), 64'd0);
    compare("error_count_o", 64'(error_count), 64'd0);
    $display("reset state: %0d errors", errors - err0);
  endtask

  task automatic run_session(input string label, output bit ok);
    int err0;
    int wr0;
    int runs0;
    err0 = errors;
    wr0 = blocks_written;
    runs0 = runs_seen;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    await_idle(1'b0, 4, ok);
    if (ok) await_host_reset(1'b1, 10, ok);
    if (ok) await_host_reset(1'b0, 100, ok);
    if (ok) begin
      compare("error_count_o after start", 64'(error_count), 64'd0);
      await_idle(1'b1, SESSION_CYCLES, ok);
    end
    if (ok) begin
      compare("error_count_o", 64'(error_count), 64'(exp_fails));
      compare("blocks written", 64'(blocks_written - wr0), 64'(n_valid));
      compare("UUT runs", 64'(runs_seen - runs0), 64'(n_valid));
      compare("first block read", 64'(first_read_blk), 64'(`AT_START_BLOCK));
      compare("last block read", 64'(last_read_blk), 64'(`AT_START_BLOCK + n_valid));
    end
    $display("%s: %0d errors", label, errors - err0);
  endtask

  initial begin
    bit ok;
    load_vectors();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_reset_state();
    run_session("session 1", ok);
    if (ok) run_session("session 2", ok);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* test/autotest_vectors.txt */
// record count, then one record per SD block from the start block on
// signature stimulus expected uut_result uut_latency uut_error
7
AABBCCDD 12345678 0000ABCD 0000ABCD 00000005 0
AABBCCDD 00000001 00000002 00000003 00000000 0
AABBCCDD DEADBEEF 11112222 11112222 00000011 1
AABBCCDD 0F0F0F0F 55AA55AA 55AA55AA 0000012C 0
AABBCCDD CAFEF00D 80000001 80000001 000000C7 0
11223344 A5A5A5A5 00000000 00000000 00000003 0
AABBCCDD 76543210 00000010 00000020 00000002 0

/* vlog.f */
+incdir+design
design/autotest_pkg.sv
design/vector_load_if.sv
design/run_if.sv
design/vector_store.sv
design/test_sequencer.sv
design/test_runner.sv
design/record_formatter.sv
design/autotest_top.sv
test/autotest_tb.sv
